// ==== src/fmt_slice_settings.svh ====
// Slice configuration settings

`ifndef FMT_SLICE_SETTINGS_SVH
`define FMT_SLICE_SETTINGS_SVH

// Datapath width in bits
`define FS_WIDTH 32

// Parallel lanes, one per FP16 half of the word
`define FS_NUM_LANES 2

// Register stages inside each lane, also the fixed latency
`define FS_PIPE_REGS 2

// Canonical quiet NaNs
`define FS_FP32_QNAN 32'h7FC0_0000
`define FS_FP16_QNAN 16'h7E00

`endif

// ==== src/fmt_slice_pkg.sv ====
// Floating-point slice types

`include "fmt_slice_settings.svh"

package fmt_slice_pkg;

  // ------------------------------------------------------------------
  // Formats and operations
  // ------------------------------------------------------------------

  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_fmt_e;

  typedef enum logic [1:0] {
    MIN   = 2'd0,
    MAX   = 2'd1,
    SGNJ  = 2'd2,
    SGNJN = 2'd3
  } op_e;

  // Bit widths of the supported formats
  localparam int unsigned FP32_BITS = 32;
  localparam int unsigned FP16_BITS = 16;

  // ------------------------------------------------------------------
  // Data words
  // ------------------------------------------------------------------

  // One datapath word, also used for lane operands
  typedef logic [`FS_WIDTH-1:0] word_t;

  // Flags in order NV DZ OF UF NX, MSB first
  typedef logic [4:0] status_t;
  localparam int unsigned STATUS_NV = 4;

  // Vector flag in bit 1, format in bit 0
  typedef logic [1:0] aux_t;

endpackage

// ==== src/lane_dispatch.sv ====
// Lane operand dispatcher

`timescale 1ns/1ns

`include "fmt_slice_settings.svh"

module lane_dispatch (
  input  logic                                      in_valid_i,
  input  fmt_slice_pkg::op_e                        op_i,
  input  fmt_slice_pkg::fp_fmt_e                    fmt_i,
  input  logic                                      vectorial_i,
  input  fmt_slice_pkg::word_t                      operand_a_i,
  input  fmt_slice_pkg::word_t                      operand_b_i,
  output logic [`FS_NUM_LANES-1:0]                  lane_valid_o,
  output fmt_slice_pkg::word_t [`FS_NUM_LANES-1:0]  lane_a_o,
  output fmt_slice_pkg::word_t [`FS_NUM_LANES-1:0]  lane_b_o,
  output fmt_slice_pkg::aux_t                       aux_o,
  output fmt_slice_pkg::op_e                        op_o,
  output fmt_slice_pkg::fp_fmt_e                    fmt_o
);

  import fmt_slice_pkg::*;

  logic        vectorial;
  logic [5:0]  lane_stride;

  // Vector operation only exists for FP16
  assign vectorial = vectorial_i & (fmt_i == FP16);

  // Distance in bits between neighbouring lane slices
  assign lane_stride = (fmt_i == FP16) ? 6'(FP16_BITS) : 6'(FP32_BITS);

  // ------------------------------------------------------------------
  // Operand slicing and lane enables
  // ------------------------------------------------------------------

  always_comb begin : slice_operands
    for (int i = 0; i < `FS_NUM_LANES; i++) begin
      // Upper bits beyond the format are ignored inside the lane
      lane_a_o[i] = operand_a_i >> (i * lane_stride);
      lane_b_o[i] = operand_b_i >> (i * lane_stride);
    end
  end

  always_comb begin : lane_enables
    lane_valid_o = '0;
    lane_valid_o[0] = in_valid_i;
    for (int i = 1; i < `FS_NUM_LANES; i++) begin
      lane_valid_o[i] = in_valid_i & vectorial;
    end
  end

  // Format info travels alongside lane 0 for the packer
  assign aux_o = {vectorial, fmt_i};
  assign op_o  = op_i;
  assign fmt_o = fmt_i;

endmodule

// ==== src/minmax_lane.sv ====
// Min/max and sign injection lane

`timescale 1ns/1ns

`include "fmt_slice_settings.svh"

module minmax_lane (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    valid_i,
  input  fmt_slice_pkg::op_e      op_i,
  input  fmt_slice_pkg::fp_fmt_e  fmt_i,
  input  fmt_slice_pkg::aux_t     aux_i,
  input  fmt_slice_pkg::word_t    operand_a_i,
  input  fmt_slice_pkg::word_t    operand_b_i,
  output logic                    valid_o,
  output fmt_slice_pkg::word_t    result_o,
  output fmt_slice_pkg::status_t  status_o,
  output fmt_slice_pkg::aux_t     aux_o
);

  import fmt_slice_pkg::*;

  // Stage 1 registers
  logic                 s1_valid_q;
  op_e                  s1_op_q;
  fp_fmt_e              s1_fmt_q;
  aux_t                 s1_aux_q;
  word_t                s1_a_q;
  word_t                s1_b_q;

  // Operand classification
  logic                 a_sign;
  logic                 b_sign;
  logic                 a_nan;
  logic                 b_nan;
  logic                 a_snan;
  logic                 b_snan;
  logic [`FS_WIDTH-2:0] a_mag;
  logic [`FS_WIDTH-2:0] b_mag;
  word_t                a_box;
  word_t                b_box;
  word_t                qnan;
  logic [4:0]           sign_pos;
  logic                 a_lt_b;
  word_t                result_d;
  status_t              status_d;

  // Stage 2 registers
  logic                 s2_valid_q;
  word_t                s2_result_q;
  status_t              s2_status_q;
  aux_t                 s2_aux_q;

  // ------------------------------------------------------------------
  // Pipeline registers
  // ------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= valid_i;
      s2_valid_q <= s1_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      s1_op_q  <= op_i;
      s1_fmt_q <= fmt_i;
      s1_aux_q <= aux_i;
      s1_a_q   <= operand_a_i;
      s1_b_q   <= operand_b_i;
    end
    if (s1_valid_q) begin
      s2_result_q <= result_d;
      s2_status_q <= status_d;
      s2_aux_q    <= s1_aux_q;
    end
  end

  // ------------------------------------------------------------------
  // Classification in the selected format
  // ------------------------------------------------------------------

  always_comb begin : classify
    if (s1_fmt_q == FP16) begin
      a_sign   = s1_a_q[15];
      b_sign   = s1_b_q[15];
      a_mag    = {{(`FS_WIDTH-FP16_BITS){1'b0}}, s1_a_q[14:0]};
      b_mag    = {{(`FS_WIDTH-FP16_BITS){1'b0}}, s1_b_q[14:0]};
      a_nan    = (&s1_a_q[14:10]) & (|s1_a_q[9:0]);
      b_nan    = (&s1_b_q[14:10]) & (|s1_b_q[9:0]);
      a_snan   = a_nan & ~s1_a_q[9];
      b_snan   = b_nan & ~s1_b_q[9];
      // Upper half is NaN-boxed inside the lane already
      a_box    = {{(`FS_WIDTH-FP16_BITS){1'b1}}, s1_a_q[15:0]};
      b_box    = {{(`FS_WIDTH-FP16_BITS){1'b1}}, s1_b_q[15:0]};
      qnan     = {{(`FS_WIDTH-FP16_BITS){1'b1}}, `FS_FP16_QNAN};
      sign_pos = 5'(FP16_BITS - 1);
    end else begin
      a_sign   = s1_a_q[31];
      b_sign   = s1_b_q[31];
      a_mag    = s1_a_q[30:0];
      b_mag    = s1_b_q[30:0];
      a_nan    = (&s1_a_q[30:23]) & (|s1_a_q[22:0]);
      b_nan    = (&s1_b_q[30:23]) & (|s1_b_q[22:0]);
      a_snan   = a_nan & ~s1_a_q[22];
      b_snan   = b_nan & ~s1_b_q[22];
      a_box    = s1_a_q;
      b_box    = s1_b_q;
      qnan     = `FS_FP32_QNAN;
      sign_pos = 5'(FP32_BITS - 1);
    end
  end

  // Sign-magnitude ordering, so -0 sorts below +0
  always_comb begin : order
    if (a_sign != b_sign) begin
      a_lt_b = a_sign;
    end else if (a_sign) begin
      a_lt_b = a_mag > b_mag;
    end else begin
      a_lt_b = a_mag < b_mag;
    end
  end

  always_comb begin : compute
    result_d = a_box;
    status_d = '0;
    unique case (s1_op_q)
      SGNJ:  result_d[sign_pos] = b_sign;
      SGNJN: result_d[sign_pos] = ~b_sign;
      default: begin
        status_d[STATUS_NV] = a_snan | b_snan;
        if (a_nan && b_nan) begin
          result_d = qnan;
        end else if (a_nan) begin
          result_d = b_box;
        end else if (b_nan) begin
          result_d = a_box;
        end else if (a_lt_b ^ (s1_op_q == MAX)) begin
          result_d = a_box;
        end else begin
          result_d = b_box;
        end
      end
    endcase
  end

  assign valid_o  = s2_valid_q;
  assign result_o = s2_result_q;
  assign status_o = s2_status_q;
  assign aux_o    = s2_aux_q;

  // Fixed two-cycle latency through both stages
  a_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_i |-> ##2 valid_o);

endmodule

// ==== src/result_pack.sv ====
// Lane result packer

`timescale 1ns/1ns

`include "fmt_slice_settings.svh"

module result_pack (
  input  logic [`FS_NUM_LANES-1:0]                    lane_valid_i,
  input  fmt_slice_pkg::word_t [`FS_NUM_LANES-1:0]    lane_result_i,
  input  fmt_slice_pkg::status_t [`FS_NUM_LANES-1:0]  lane_status_i,
  input  fmt_slice_pkg::aux_t                         aux_i,
  output logic                                        out_valid_o,
  output fmt_slice_pkg::word_t                        result_o,
  output fmt_slice_pkg::status_t                      status_o
);

  import fmt_slice_pkg::*;

  logic    res_vec;
  fp_fmt_e res_fmt;

  // Decode the format info carried by lane 0
  assign res_vec = aux_i[1];
  assign res_fmt = fp_fmt_e'(aux_i[0]);

  // ------------------------------------------------------------------
  // Result packing
  // ------------------------------------------------------------------

  always_comb begin : pack
    if (res_fmt == FP16) begin
      // Halves without a result stay NaN-boxed
      result_o = '1;
      for (int i = 0; i < `FS_NUM_LANES; i++) begin
        if (i == 0 || (res_vec && lane_valid_i[i])) begin
          result_o[i*FP16_BITS +: FP16_BITS] = lane_result_i[i][FP16_BITS-1:0];
        end
      end
    end else begin
      result_o = lane_result_i[0];
    end
  end

  // Only lanes that carried an operation contribute flags
  always_comb begin : collapse_status
    status_o = '0;
    for (int i = 0; i < `FS_NUM_LANES; i++) begin
      if (lane_valid_i[i]) begin
        status_o |= lane_status_i[i];
      end
    end
  end

  assign out_valid_o = lane_valid_i[0];

  // Upper lanes only ever run together with lane 0
  a_lane0_leads: assert final ($isunknown(lane_valid_i) || lane_valid_i[0]
                               || (lane_valid_i == '0));

endmodule

// ==== src/fmt_slice_top.sv ====
// Multi-format FP slice top level

`timescale 1ns/1ns

`include "fmt_slice_settings.svh"

module fmt_slice_top (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    in_valid_i,
  input  fmt_slice_pkg::op_e      op_i,
  input  fmt_slice_pkg::fp_fmt_e  fmt_i,
  input  logic                    vectorial_i,
  input  fmt_slice_pkg::word_t    operand_a_i,
  input  fmt_slice_pkg::word_t    operand_b_i,
  output logic                    out_valid_o,
  output fmt_slice_pkg::word_t    result_o,
  output fmt_slice_pkg::status_t  status_o
);

  import fmt_slice_pkg::*;

  // Dispatcher to lanes
  logic [`FS_NUM_LANES-1:0]    lane_valid;
  word_t [`FS_NUM_LANES-1:0]   lane_a;
  word_t [`FS_NUM_LANES-1:0]   lane_b;
  aux_t                        dispatch_aux;
  op_e                         lane_op;
  fp_fmt_e                     lane_fmt;

  // Lanes to packer, aux of lane 0 drives the packing
  logic [`FS_NUM_LANES-1:0]    lane_out_valid;
  word_t [`FS_NUM_LANES-1:0]   lane_result;
  status_t [`FS_NUM_LANES-1:0] lane_status;
  aux_t [`FS_NUM_LANES-1:0]    lane_aux;

  lane_dispatch u_dispatch (
    .in_valid_i   (in_valid_i),
    .op_i         (op_i),
    .fmt_i        (fmt_i),
    .vectorial_i  (vectorial_i),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .lane_valid_o (lane_valid),
    .lane_a_o     (lane_a),
    .lane_b_o     (lane_b),
    .aux_o        (dispatch_aux),
    .op_o         (lane_op),
    .fmt_o        (lane_fmt)
  );

  for (genvar i = 0; i < `FS_NUM_LANES; i++) begin : gen_lanes
    minmax_lane u_lane (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .valid_i     (lane_valid[i]),
      .op_i        (lane_op),
      .fmt_i       (lane_fmt),
      .aux_i       (dispatch_aux),
      .operand_a_i (lane_a[i]),
      .operand_b_i (lane_b[i]),
      .valid_o     (lane_out_valid[i]),
      .result_o    (lane_result[i]),
      .status_o    (lane_status[i]),
      .aux_o       (lane_aux[i])
    );
  end

  result_pack u_pack (
    .lane_valid_i  (lane_out_valid),
    .lane_result_i (lane_result),
    .lane_status_i (lane_status),
    .aux_i         (lane_aux[0]),
    .out_valid_o   (out_valid_o),
    .result_o      (result_o),
    .status_o      (status_o)
  );

endmodule

// ==== dv/tb_fmt_slice.sv ====
// Floating-point slice testbench

`timescale 1ns/1ns

`include "fmt_slice_settings.svh"

module tb_fmt_slice;

  import fmt_slice_pkg::*;

  localparam int NUM_DIRECTED = 6;
  localparam int NUM_RANDOM   = 400;
  localparam int NUM_OPS      = NUM_DIRECTED + NUM_RANDOM;
  // Each operation takes at most two cycles including an idle gap
  localparam int MAX_CYCLES   = NUM_OPS * 2 + 50;

  logic     clk_i;
  logic     rst_n_i;
  logic     in_valid_i;
  op_e      op_i;
  fp_fmt_e  fmt_i;
  logic     vectorial_i;
  word_t    operand_a_i;
  word_t    operand_b_i;
  logic     out_valid_o;
  word_t    result_o;
  status_t  status_o;

  int          cycle_cnt = 0;
  logic [31:0] lcg_state;

  // Expected responses in issue order
  word_t   exp_result_q[$];
  status_t exp_status_q[$];
  int      exp_cycle_q[$];

  fmt_slice_top u_dut (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (in_valid_i),
    .op_i        (op_i),
    .fmt_i       (fmt_i),
    .vectorial_i (vectorial_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .out_valid_o (out_valid_o),
    .result_o    (result_o),
    .status_o    (status_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // ------------------------------------------------------------------
  // Failure reporting and checks
  // ------------------------------------------------------------------

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "Stopping on first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      report_failure($sformatf("** Error: %s = 0x%08h, expected 0x%08h",
                               name, actual, expected));
    end
  endtask

  // ------------------------------------------------------------------
  // Random numbers and reference model
  // ------------------------------------------------------------------

  // Upper half of the state since the low LCG bits repeat quickly
  function logic [15:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];
  endfunction

  function automatic logic [15:0] rand_fp16();
    logic [15:0] r;
    logic [2:0]  sel;
    r   = lcg_next();
    sel = lcg_next() % 8;
    case (sel)
      3'd0:    return {r[15], 5'h1F, 1'b1, r[8:0]};
      3'd1:    return {r[15], 5'h1F, 1'b0, r[8:1], 1'b1};
      3'd2:    return 16'h0000;
      3'd3:    return 16'h8000;
      3'd4:    return {r[15], 5'h1F, 10'h000};
      default: return r;
    endcase
  endfunction

  function automatic logic [31:0] rand_fp32();
    logic [31:0] r;
    logic [2:0]  sel;
    r   = {lcg_next(), lcg_next()};
    sel = lcg_next() % 8;
    case (sel)
      3'd0:    return {r[31], 8'hFF, 1'b1, r[21:0]};
      3'd1:    return {r[31], 8'hFF, 1'b0, r[21:1], 1'b1};
      3'd2:    return 32'h0000_0000;
      3'd3:    return 32'h8000_0000;
      3'd4:    return {r[31], 8'hFF, 23'h0};
      default: return r;
    endcase
  endfunction

  // Models one lane and returns {nv, result} in the low format bits
  function automatic logic [32:0] model_lane(input op_e op, input logic is16,
                                             input logic [31:0] a, input logic [31:0] b);
    int unsigned w;
    int unsigned mb;
    logic [31:0] mask;
    logic [31:0] emask;
    logic [31:0] qnan;
    logic [31:0] ra;
    logic [31:0] rb;
    logic [31:0] res;
    logic        na;
    logic        nb;
    logic        nv;
    longint      ka;
    longint      kb;
    w     = is16 ? 16 : 32;
    mb    = is16 ? 10 : 23;
    mask  = is16 ? 32'h0000_FFFF : 32'hFFFF_FFFF;
    emask = mask >> (mb + 1);
    qnan  = is16 ? 32'(`FS_FP16_QNAN) : `FS_FP32_QNAN;
    ra    = a & mask;
    rb    = b & mask;
    na    = (((ra >> mb) & emask) == emask) && ((ra & ((32'd1 << mb) - 1)) != 0);
    nb    = (((rb >> mb) & emask) == emask) && ((rb & ((32'd1 << mb) - 1)) != 0);
    // Ordered keys where -0 maps just below +0
    ka    = ra[w-1] ? -longint'(ra & (mask >> 1)) - 1 : longint'(ra & (mask >> 1));
    kb    = rb[w-1] ? -longint'(rb & (mask >> 1)) - 1 : longint'(rb & (mask >> 1));
    nv    = 1'b0;
    res   = ra;
    if (op == SGNJ) begin
      res[w-1] = rb[w-1];
    end else if (op == SGNJN) begin
      res[w-1] = ~rb[w-1];
    end else begin
      nv = (na && !ra[mb-1]) || (nb && !rb[mb-1]);
      if (na && nb) begin
        res = qnan;
      end else if (na) begin
        res = rb;
      end else if (nb) begin
        res = ra;
      end else if (op == MIN) begin
        res = (ka <= kb) ? ra : rb;
      end else begin
        res = (ka >= kb) ? ra : rb;
      end
    end
    return {nv, res};
  endfunction

  // ------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------

  // Called on a falling edge and returns one falling edge later
  task automatic issue(input op_e op, input fp_fmt_e fmt, input logic vec,
                       input word_t a, input word_t b);
    logic [32:0] l0;
    logic [32:0] l1;
    word_t       exp_res;
    logic        nv;
    in_valid_i  = 1'b1;
    op_i        = op;
    fmt_i       = fmt;
    vectorial_i = vec;
    operand_a_i = a;
    operand_b_i = b;
    if (fmt == FP16) begin
      l0 = model_lane(op, 1'b1, a, b);
      if (vec) begin
        l1      = model_lane(op, 1'b1, a >> 16, b >> 16);
        exp_res = {l1[15:0], l0[15:0]};
        nv      = l0[32] | l1[32];
      end else begin
        exp_res = {16'hFFFF, l0[15:0]};
        nv      = l0[32];
      end
    end else begin
      // Vector flag has no meaning for FP32
      l0      = model_lane(op, 1'b0, a, b);
      exp_res = l0[31:0];
      nv      = l0[32];
    end
    exp_result_q.push_back(exp_res);
    exp_status_q.push_back({nv, 4'b0000});
    exp_cycle_q.push_back(cycle_cnt + `FS_PIPE_REGS);
    @(negedge clk_i);
    in_valid_i = 1'b0;
  endtask

  initial begin
    op_e     op;
    fp_fmt_e fmt;
    logic    vec;
    word_t   a;
    word_t   b;
    lcg_state   = 32'd12;
    rst_n_i     = 1'b0;
    in_valid_i  = 1'b0;
    op_i        = MIN;
    fmt_i       = FP32;
    vectorial_i = 1'b0;
    operand_a_i = '0;
    operand_b_i = '0;
    repeat (5) @(negedge clk_i);
    rst_n_i = 1'b1;

    // No result may appear before the first strobe
    repeat (3) begin
      @(negedge clk_i);
      check_value("out_valid_o", out_valid_o, 32'd0);
    end

    // Directed corners issued back to back
    issue(MIN, FP32, 1'b0, 32'h0000_0000, 32'h8000_0000);
    issue(MAX, FP32, 1'b0, 32'h8000_0000, 32'h0000_0000);
    issue(MIN, FP32, 1'b0, 32'h7FC1_2345, 32'hFF80_0001);
    issue(MAX, FP16, 1'b0, 32'hDEAD_3C00, 32'h1234_BC00);
    issue(SGNJN, FP16, 1'b1, 32'h7C01_BC00, 32'h0000_8000);
    issue(MIN, FP32, 1'b1, 32'h7F80_0001, 32'h4049_0FDB);
    repeat (3) @(negedge clk_i);

    for (int n = 0; n < NUM_RANDOM; n++) begin
      op  = op_e'(lcg_next() % 4);
      fmt = fp_fmt_e'(lcg_next() % 2);
      vec = lcg_next() % 2;
      if (fmt == FP16) begin
        a = {rand_fp16(), rand_fp16()};
        b = {rand_fp16(), rand_fp16()};
      end else begin
        a = rand_fp32();
        b = rand_fp32();
      end
      // Equal operands and sign-flipped twins hit the tie cases
      case (lcg_next() % 8)
        0:       b = a;
        1:       b = a ^ ((fmt == FP16) ? 32'h8000_8000 : 32'h8000_0000);
        default: b = b;
      endcase
      issue(op, fmt, vec, a, b);
      if (lcg_next() % 4 == 0) begin
        @(negedge clk_i);
      end
    end

    repeat (`FS_PIPE_REGS + 2) @(negedge clk_i);
    if (exp_cycle_q.size() != 0) begin
      report_failure("Results still outstanding at the end of the run");
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

  // ------------------------------------------------------------------
  // Response monitor and timeout
  // ------------------------------------------------------------------

  always @(negedge clk_i) begin
    if (rst_n_i) begin
      if (out_valid_o === 1'b1) begin
        if (exp_cycle_q.size() == 0) begin
          report_failure("out_valid_o went high with no operation outstanding");
        end
        check_value("out_valid_o arrival cycle", cycle_cnt, exp_cycle_q.pop_front());
        check_value("result_o", result_o, exp_result_q.pop_front());
        check_value("status_o", status_o, exp_status_q.pop_front());
      end else if (exp_cycle_q.size() != 0 && cycle_cnt >= exp_cycle_q[0]) begin
        report_failure("An expected result did not arrive on time");
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > MAX_CYCLES) begin
      report_failure($sformatf("Run did not finish within %0d cycles", MAX_CYCLES));
    end
  end

endmodule

// ==== fmt_slice.f ====
+incdir+src
src/fmt_slice_pkg.sv
src/lane_dispatch.sv
src/minmax_lane.sv
src/result_pack.sv
src/fmt_slice_top.sv
dv/tb_fmt_slice.sv

// ==== Bender.yml ====
package:
  name: fmt_slice

export_include_dirs:
  - src

sources:
  - files:
      - src/fmt_slice_pkg.sv
      - src/lane_dispatch.sv
      - src/minmax_lane.sv
      - src/result_pack.sv
      - src/fmt_slice_top.sv
  - target: test
    files:
      - dv/tb_fmt_slice.sv
